/* design/mips_settings.svh */
// MIPS core settings
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define MIPS_DATA_W   32
`define MIPS_ADDR_W   32
`define MIPS_REG_N    32
`define MIPS_REG_AW   5
`define MIPS_RESET_PC 32'h0000_0000

// primary opcodes, inst[31:26]
`define MIPS_OPC_SPECIAL 6'b000000
`define MIPS_OPC_ANDI    6'b001100
`define MIPS_OPC_ORI     6'b001101
`define MIPS_OPC_XORI    6'b001110
`define MIPS_OPC_LUI     6'b001111

// SPECIAL function codes, inst[5:0]
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR  6'b100101
`define MIPS_FN_XOR 6'b100110
`define MIPS_FN_NOR 6'b100111

`endif

/* design/mips_pkg.sv */
// MIPS core types
`include "mips_settings.svh"

package mips_pkg;

    // one data or instruction word
    typedef logic [`MIPS_DATA_W-1:0] word_t;

    // byte address into the instruction ROM
    typedef logic [`MIPS_ADDR_W-1:0] inst_addr_t;

    // register number
    typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;

    // operation within the selected class
    typedef enum logic [2:0] {
        OP_NOP,
        OP_OR,
        OP_AND,
        OP_XOR,
        OP_NOR,
        OP_LUI
    } alu_op_t;

    // result class, only logic ops for now
    typedef enum logic [0:0] {
        SEL_NONE,
        SEL_LOGIC
    } alu_sel_t;

endpackage

/* design/mips_ifs.sv */
// Pipeline interfaces
`timescale 1ns/1ps

// decoded instruction, ID/EX register contents
interface dec_ex_if;
    import mips_pkg::*;

    alu_op_t  alu_op;
    alu_sel_t alu_sel;
    word_t    op1;
    word_t    op2;
    reg_idx_t waddr;
    logic     wreg;

    modport src (
        output alu_op, alu_sel, op1, op2, waddr, wreg
    );

    modport dst (
        input alu_op, alu_sel, op1, op2, waddr, wreg
    );
endinterface

// two register read ports, answered combinationally
interface rf_rd_if;
    import mips_pkg::*;

    logic     re1;
    reg_idx_t raddr1;
    logic     re2;
    reg_idx_t raddr2;
    word_t    rdata1;
    word_t    rdata2;

    modport req (output re1, raddr1, re2, raddr2, input rdata1, rdata2);
    modport rsp (input re1, raddr1, re2, raddr2, output rdata1, rdata2);
endinterface

/* design/fetch_unit.sv */
// Instruction fetch
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetch_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  mips_pkg::word_t      rom_data_i,
    output logic                 rom_ce_o,
    output mips_pkg::inst_addr_t rom_addr_o,
    output mips_pkg::word_t      id_pc_o,
    output mips_pkg::word_t      id_inst_o
);
    import mips_pkg::*;

    inst_addr_t pc;
    word_t      fetched;

    // enable comes up one edge after reset is released
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rom_ce_o <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
        end
    end

    // pc parks at the reset address until fetching starts
    always_ff @(posedge clk_i) begin
        if (!rom_ce_o) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= pc + inst_addr_t'(4);
        end
    end

    assign rom_addr_o = pc;

    // no enable, no instruction: feed a NOP
    assign fetched = rom_ce_o ? rom_data_i : '0;

    // IF/ID register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            id_inst_o <= '0;
        end else begin
            id_inst_o <= fetched;
        end
        id_pc_o <= pc;
    end

endmodule

/* design/decode_unit.sv */
// Instruction decode
`timescale 1ns/1ps
`include "mips_settings.svh"

module decode_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  mips_pkg::word_t    id_pc_i,
    input  mips_pkg::word_t    id_inst_i,
    rf_rd_if.req               rd,
    dec_ex_if.src              dx,
    input  logic               ex_fwd_we_i,
    input  mips_pkg::reg_idx_t ex_fwd_waddr_i,
    input  mips_pkg::word_t    ex_fwd_data_i,
    input  logic               mem_fwd_we_i,
    input  mips_pkg::reg_idx_t mem_fwd_waddr_i,
    input  mips_pkg::word_t    mem_fwd_data_i
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_idx_t    rs_idx;
    reg_idx_t    rt_idx;
    reg_idx_t    rd_idx;
    logic [15:0] imm;

    alu_op_t     alu_op;
    alu_sel_t    alu_sel;
    reg_idx_t    waddr;
    logic        wreg;
    word_t       imm_val;
    word_t       op1;
    word_t       op2;

    // newest value wins: EX, then MEM, then the register file
    function automatic word_t fwd_sel(input reg_idx_t idx, input word_t rf_data);
        word_t val;
        val = rf_data;
        if (idx != '0) begin
            if (ex_fwd_we_i && ex_fwd_waddr_i == idx) begin
                val = ex_fwd_data_i;
            end else if (mem_fwd_we_i && mem_fwd_waddr_i == idx) begin
                val = mem_fwd_data_i;
            end
        end
        return val;
    endfunction

    assign opcode = id_inst_i[31:26];
    assign rs_idx = id_inst_i[25:21];
    assign rt_idx = id_inst_i[20:16];
    assign rd_idx = id_inst_i[15:11];
    assign imm    = id_inst_i[15:0];
    assign funct  = id_inst_i[5:0];

    assign rd.raddr1 = rs_idx;
    assign rd.raddr2 = rt_idx;

    always_comb begin
        alu_op  = OP_NOP;
        alu_sel = SEL_NONE;
        wreg    = 1'b0;
        waddr   = rt_idx;
        rd.re1  = 1'b0;
        rd.re2  = 1'b0;
        imm_val = {16'h0000, imm};

        case (opcode)
            `MIPS_OPC_SPECIAL: begin
                waddr = rd_idx;
                case (funct)
                    `MIPS_FN_AND: alu_op = OP_AND;
                    `MIPS_FN_OR:  alu_op = OP_OR;
                    `MIPS_FN_XOR: alu_op = OP_XOR;
                    `MIPS_FN_NOR: alu_op = OP_NOR;
                    default:      alu_op = OP_NOP;
                endcase
            end
            `MIPS_OPC_ORI:  alu_op = OP_OR;
            `MIPS_OPC_ANDI: alu_op = OP_AND;
            `MIPS_OPC_XORI: alu_op = OP_XOR;
            `MIPS_OPC_LUI: begin
                alu_op  = OP_LUI;
                imm_val = {imm, 16'h0000};
            end
            default: alu_op = OP_NOP;
        endcase

        // anything left as NOP reads and writes nothing
        if (alu_op != OP_NOP) begin
            alu_sel = SEL_LOGIC;
            wreg    = 1'b1;
            rd.re1  = (alu_op != OP_LUI);
            rd.re2  = (opcode == `MIPS_OPC_SPECIAL);
        end
    end

    always_comb begin
        op1 = rd.re1 ? fwd_sel(rs_idx, rd.rdata1) : imm_val;
        op2 = rd.re2 ? fwd_sel(rt_idx, rd.rdata2) : imm_val;
    end

    // ID/EX register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dx.alu_op  <= OP_NOP;
            dx.alu_sel <= SEL_NONE;
            dx.wreg    <= 1'b0;
        end else begin
            dx.alu_op  <= alu_op;
            dx.alu_sel <= alu_sel;
            dx.wreg    <= wreg;
        end
    end

    always_ff @(posedge clk_i) begin
        dx.op1   <= op1;
        dx.op2   <= op2;
        dx.waddr <= waddr;
    end

endmodule

/* design/reg_file.sv */
// Register file
`timescale 1ns/1ps
`include "mips_settings.svh"

module reg_file (
    input  logic               clk_i,
    input  logic               rst_n_i,
    rf_rd_if.rsp               rd,
    input  logic               we_i,
    input  mips_pkg::reg_idx_t waddr_i,
    input  mips_pkg::word_t    wdata_i
);
    import mips_pkg::*;

    word_t regs [`MIPS_REG_N];

    // r0 is never written
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `MIPS_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-back in the same cycle is passed straight to the reader
    function automatic word_t read_port(input logic re, input reg_idx_t addr);
        word_t val;
        if (!re || addr == '0) begin
            val = '0;
        end else if (we_i && addr == waddr_i) begin
            val = wdata_i;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rd.rdata1 = read_port(rd.re1, rd.raddr1);
        rd.rdata2 = read_port(rd.re2, rd.raddr2);
    end

endmodule

/* design/exec_unit.sv */
// Execute, memory and write-back stages
`timescale 1ns/1ps

module exec_unit (
    input  logic               clk_i,
    input  logic               rst_n_i,
    dec_ex_if.dst              dx,
    output logic               ex_fwd_we_o,
    output mips_pkg::reg_idx_t ex_fwd_waddr_o,
    output mips_pkg::word_t    ex_fwd_data_o,
    output logic               mem_fwd_we_o,
    output mips_pkg::reg_idx_t mem_fwd_waddr_o,
    output mips_pkg::word_t    mem_fwd_data_o,
    output logic               wb_we_o,
    output mips_pkg::reg_idx_t wb_waddr_o,
    output mips_pkg::word_t    wb_wdata_o
);
    import mips_pkg::*;

    word_t logic_res;

    // logic ALU
    always_comb begin
        case (dx.alu_op)
            OP_OR:   logic_res = dx.op1 | dx.op2;
            OP_AND:  logic_res = dx.op1 & dx.op2;
            OP_XOR:  logic_res = dx.op1 ^ dx.op2;
            OP_NOR:  logic_res = ~(dx.op1 | dx.op2);
            // operand already shifted up in decode
            OP_LUI:  logic_res = dx.op2;
            default: logic_res = '0;
        endcase
    end

    // writes to r0 and NOPs are dropped here
    assign ex_fwd_we_o    = dx.wreg && (dx.alu_op != OP_NOP) && (dx.waddr != '0);
    assign ex_fwd_waddr_o = dx.waddr;
    assign ex_fwd_data_o  = (dx.alu_sel == SEL_LOGIC) ? logic_res : '0;

    // EX/MEM register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_fwd_we_o <= 1'b0;
        end else begin
            mem_fwd_we_o <= ex_fwd_we_o;
        end
        mem_fwd_waddr_o <= ex_fwd_waddr_o;
        mem_fwd_data_o  <= ex_fwd_data_o;
    end

    // MEM/WB register, no memory access in between
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= mem_fwd_we_o;
        end
        wb_waddr_o <= mem_fwd_waddr_o;
        wb_wdata_o <= mem_fwd_data_o;
    end

endmodule

/* design/openmips.sv */
// OpenMIPS core top level
`timescale 1ns/1ps

module openmips (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  mips_pkg::word_t      rom_data_i,
    output logic                 rom_ce_o,
    output mips_pkg::inst_addr_t rom_addr_o,
    output logic                 wb_we_o,
    output mips_pkg::reg_idx_t   wb_waddr_o,
    output mips_pkg::word_t      wb_wdata_o
);
    import mips_pkg::*;

    // IF/ID
    word_t    id_pc;
    word_t    id_inst;

    // forwarding sources
    logic     ex_fwd_we;
    reg_idx_t ex_fwd_waddr;
    word_t    ex_fwd_data;
    logic     mem_fwd_we;
    reg_idx_t mem_fwd_waddr;
    word_t    mem_fwd_data;

    dec_ex_if i_dx ();
    rf_rd_if  i_rd ();

    fetch_unit i_fetch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rom_data_i (rom_data_i),
        .rom_ce_o   (rom_ce_o),
        .rom_addr_o (rom_addr_o),
        .id_pc_o    (id_pc),
        .id_inst_o  (id_inst)
    );

    decode_unit i_decode (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .id_pc_i         (id_pc),
        .id_inst_i       (id_inst),
        .rd              (i_rd.req),
        .dx              (i_dx.src),
        .ex_fwd_we_i     (ex_fwd_we),
        .ex_fwd_waddr_i  (ex_fwd_waddr),
        .ex_fwd_data_i   (ex_fwd_data),
        .mem_fwd_we_i    (mem_fwd_we),
        .mem_fwd_waddr_i (mem_fwd_waddr),
        .mem_fwd_data_i  (mem_fwd_data)
    );

    // write port fed by the commit signals
    reg_file i_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rd      (i_rd.rsp),
        .we_i    (wb_we_o),
        .waddr_i (wb_waddr_o),
        .wdata_i (wb_wdata_o)
    );

    exec_unit i_exec (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .dx              (i_dx.dst),
        .ex_fwd_we_o     (ex_fwd_we),
        .ex_fwd_waddr_o  (ex_fwd_waddr),
        .ex_fwd_data_o   (ex_fwd_data),
        .mem_fwd_we_o    (mem_fwd_we),
        .mem_fwd_waddr_o (mem_fwd_waddr),
        .mem_fwd_data_o  (mem_fwd_data),
        .wb_we_o         (wb_we_o),
        .wb_waddr_o      (wb_waddr_o),
        .wb_wdata_o      (wb_wdata_o)
    );

endmodule

/* tests/openmips_props.sv */
// Fetch and commit properties
`timescale 1ns/1ps
`include "mips_settings.svh"

module openmips_props (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    rom_ce_o,
    input logic [`MIPS_ADDR_W-1:0] rom_addr_o,
    input logic                    wb_we_o,
    input logic [`MIPS_REG_AW-1:0] wb_waddr_o
);

    // control outputs follow a reset edge low
    ce_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !rom_ce_o)
        else $error("rom_ce_o high after a reset edge");

    we_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !wb_we_o)
        else $error("wb_we_o high after a reset edge");

    // sequential fetch, one word per cycle
    addr_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rom_ce_o |=> rom_addr_o == $past(rom_addr_o) + 32'd4)
        else $error("rom_addr_o did not advance by 4");

    no_r0_commit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_we_o |-> wb_waddr_o != '0)
        else $error("commit to register 0");

endmodule

bind openmips openmips_props i_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rom_ce_o   (rom_ce_o),
    .rom_addr_o (rom_addr_o),
    .wb_we_o    (wb_we_o),
    .wb_waddr_o (wb_waddr_o)
);

/* tests/openmips_tb.sv */
// OpenMIPS core testbench
`timescale 1ns/1ps
`include "mips_settings.svh"

module openmips_tb;
    import mips_pkg::*;

    localparam int TEST_SLACK   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int DRAIN_CYCLES = 6;
    localparam int COMMIT_WAIT  = 8;

    logic       clk;
    logic       rst_n;
    word_t      rom_data;
    logic       rom_ce;
    inst_addr_t rom_addr;
    logic       wb_we;
    reg_idx_t   wb_waddr;
    word_t      wb_wdata;

    // test file contents
    string    test_name [$];
    int       test_first_inst [$];
    int       test_inst_n [$];
    int       test_first_commit [$];
    int       test_commit_n [$];
    word_t    inst_words [$];
    reg_idx_t exp_reg [$];
    word_t    exp_val [$];

    // ROM contents of the running test
    word_t    rom_mem [$];
    int       rom_idx;

    // words fetched in the last cycles, newest first
    word_t    fetch_hist [$];

    int         cycles;
    int         cycle_limit;
    bit         in_reset;
    inst_addr_t exp_addr;
    int         exp_pos;
    int         exp_end;
    int         test_errors;
    int         total_errors;
    int         tests_passed;
    int         tests_failed;

    openmips i_dut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .rom_data_i (rom_data),
        .rom_ce_o   (rom_ce),
        .rom_addr_o (rom_addr),
        .wb_we_o    (wb_we),
        .wb_waddr_o (wb_waddr),
        .wb_wdata_o (wb_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit on the cycles stepped by the test sequence
    initial begin
        wait (cycles > cycle_limit);
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // combinational ROM, zero past the end of the program
    assign rom_idx  = int'(rom_addr[31:2]);
    assign rom_data = (rom_ce && rom_idx < rom_mem.size()) ? rom_mem[rom_idx] : '0;

    // register an instruction writes, from the MIPS field layout
    function automatic reg_idx_t dest_reg_of(input word_t inst);
        if (inst[31:26] == `MIPS_OPC_SPECIAL) begin
            return inst[15:11];
        end
        return inst[20:16];
    endfunction

    task automatic load_tests();
        int    fd;
        int    code;
        int    n_inst;
        int    n_commit;
        string tok;
        string rest;
        string name;
        word_t word;
        word_t val;
        fd = $fopen("tests/openmips_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/openmips_tests.txt");
            total_errors++;
        end else begin
            n_inst = 0;
            n_commit = 0;
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "test") begin
                    code = $fscanf(fd, "%s", name);
                    n_inst = 0;
                    n_commit = 0;
                end else if (tok == "inst") begin
                    code = $fscanf(fd, "%h", word);
                    inst_words.push_back(word);
                    n_inst++;
                end else if (tok == "commit") begin
                    code = $fscanf(fd, "%h %h", word, val);
                    exp_reg.push_back(word[4:0]);
                    exp_val.push_back(val);
                    n_commit++;
                end else if (tok == "end") begin
                    test_name.push_back(name);
                    test_first_inst.push_back(inst_words.size() - n_inst);
                    test_inst_n.push_back(n_inst);
                    test_first_commit.push_back(exp_val.size() - n_commit);
                    test_commit_n.push_back(n_commit);
                end else begin
                    $display("unexpected token %s in the test file", tok);
                    total_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_commit();
        reg_idx_t want_reg;
        word_t    want_val;
        word_t    src;
        src = fetch_hist[3];
        if (src == '0 || dest_reg_of(src) != wb_waddr) begin
            $display("commit to r%0d does not match the instruction fetched 4 cycles earlier",
                     wb_waddr);
            test_errors++;
        end
        if (exp_pos >= exp_end) begin
            $display("extra commit: r%0d written with %h after the last expected one",
                     wb_waddr, wb_wdata);
            test_errors++;
        end else begin
            want_reg = exp_reg[exp_pos];
            want_val = exp_val[exp_pos];
            exp_pos++;
            if (wb_waddr !== want_reg) begin
                $display("Error: wb_waddr_o is %h, expected %h", wb_waddr, want_reg);
                test_errors++;
            end
            if (wb_wdata !== want_val) begin
                $display("Error: wb_wdata_o is %h, expected %h", wb_wdata, want_val);
                test_errors++;
            end
        end
    endtask

    // one clock, outputs sampled at the falling edge
    task automatic step_cycle();
        word_t fetched;
        @(negedge clk);
        cycles++;
        if (in_reset) begin
            if (rom_ce !== 1'b0) begin
                $display("rom_ce_o was not low while reset was held");
                test_errors++;
            end
            if (wb_we !== 1'b0) begin
                $display("wb_we_o was not low while reset was held");
                test_errors++;
            end
        end else begin
            if (rom_ce !== 1'b1) begin
                $display("rom_ce_o did not go high after reset");
                test_errors++;
            end else if (rom_addr !== exp_addr) begin
                $display("Error: rom_addr_o is %h, expected %h", rom_addr, exp_addr);
                test_errors++;
            end
            exp_addr = exp_addr + 32'd4;
            if (wb_we === 1'b1) begin
                check_commit();
            end
            fetched = (rom_ce === 1'b1) ? rom_data : '0;
            fetch_hist.push_front(fetched);
            void'(fetch_hist.pop_back());
        end
    endtask

    task automatic run_test(input int t);
        int waited;
        rom_mem.delete();
        for (int i = 0; i < test_inst_n[t]; i++) begin
            rom_mem.push_back(inst_words[test_first_inst[t] + i]);
        end
        test_errors = 0;
        rst_n = 1'b0;
        in_reset = 1'b1;
        repeat (RESET_CYCLES) step_cycle();
        rst_n = 1'b1;
        in_reset = 1'b0;
        exp_addr = `MIPS_RESET_PC;
        fetch_hist = {32'h0, 32'h0, 32'h0, 32'h0};
        exp_pos = test_first_commit[t];
        exp_end = exp_pos + test_commit_n[t];
        waited = 0;
        while (exp_pos < exp_end && waited < test_inst_n[t] + COMMIT_WAIT) begin
            step_cycle();
            waited++;
        end
        if (exp_pos < exp_end) begin
            $display("%0d of %0d expected commits never appeared",
                     exp_end - exp_pos, test_commit_n[t]);
            test_errors++;
        end
        // late or extra commits would show up here
        repeat (DRAIN_CYCLES) step_cycle();
        $display("test %0d %s: %s, %0d commits expected, %0d errors", t, test_name[t],
                 (test_errors == 0) ? "passed" : "failed", test_commit_n[t], test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    initial begin
        rst_n = 1'b0;
        in_reset = 1'b1;
        cycles = 0;
        cycle_limit = 1000;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_tests();
        cycle_limit = inst_words.size() + TEST_SLACK * test_name.size();
        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end
        $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 test_name.size(), tests_passed, tests_failed, total_errors);
        if (test_name.size() > 0 && tests_failed == 0 && total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tests/openmips_tests.txt */
# columns: test <name> | inst <hex word>, in fetch order | commit <reg hex> <value hex> | end
# commits are listed in program order, instructions without a commit have no entry
test immediates
inst 34011234
inst 3422F0F0
inst 3C03ABCD
inst 34635678
inst 3064FF00
inst 3865FFFF
inst 3C06FFFF
commit 01 00001234
commit 02 0000F2F4
commit 03 ABCD0000
commit 03 ABCD5678
commit 04 00005600
commit 05 ABCDA987
commit 06 FFFF0000
end
test rtype_logic
inst 3C01F0F0
inst 342100FF
inst 34020FF0
inst 00221824
inst 00222025
inst 00222826
inst 00223027
commit 01 F0F00000
commit 01 F0F000FF
commit 02 00000FF0
commit 03 000000F0
commit 04 F0F00FFF
commit 05 F0F00F0F
commit 06 0F0FF000
end
test forwarding
inst 34010001
inst 34020002
inst 34030004
inst 34040008
inst 34850010
inst 00A43026
inst 00C33825
inst 00A74024
inst 34210100
inst 34210200
inst 00224825
commit 01 00000001
commit 02 00000002
commit 03 00000004
commit 04 00000008
commit 05 00000018
commit 06 00000010
commit 07 00000014
commit 08 00000010
commit 01 00000101
commit 01 00000301
commit 09 00000303
end
test r0_and_nops
inst 34001234
inst 340100AA
inst 00000000
inst FC000000
inst 00221820
inst 00201025
inst 00210026
inst 00001825
inst 3C00FFFF
inst 34040055
commit 01 000000AA
commit 02 000000AA
commit 03 00000000
commit 04 00000055
end

/* build.f */
+incdir+design
design/mips_pkg.sv
design/mips_ifs.sv
design/fetch_unit.sv
design/decode_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/openmips.sv
tests/openmips_props.sv
tests/openmips_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Mdir obj_dir
TOP      := openmips_tb
FILELIST := build.f

PASS_MSG := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
